/* src/rider_consts.svh */
`ifndef RIDER_CONSTS_SVH
`define RIDER_CONSTS_SVH

// Firmware revision, low three bytes of the status word
`define MAJOR_REV 8'd1
`define MINOR_REV 8'd4
`define PATCH_REV 8'd2

// Host register address width, 16 words in the map
`define REG_ADDR_W 4

// Read-only status words
`define ADDR_STATUS    4'd0
`define ADDR_ERRORS    4'd1
`define ADDR_CS_COUNT  4'd2
`define ADDR_UNK_COUNT 4'd3
`define ADDR_OVF_COUNT 4'd4
`define ADDR_TRIG_NUM  4'd5
`define ADDR_TS_LSB    4'd6
`define ADDR_TS_MSB    4'd7
`define ADDR_RAW_TRIG  4'd8
`define ADDR_ACC_TRIG  4'd9
`define ADDR_TTC       4'd10
`define ADDR_FSM       4'd11

// Writable words; clear is write-only and reads as zero
`define ADDR_THRES_CS  4'd12
`define ADDR_THRES_UNK 4'd13
`define ADDR_THRES_OVF 4'd14
`define ADDR_CLEAR     4'd15

`endif

/* src/rider_status_pkg.sv */
`default_nettype none

package rider_status_pkg;

  // Board configuration, top three bits of the status word
  typedef struct packed {
    logic is_golden;
    logic async_mode;
    logic prog_chan_done;
  } board_flags_t;

  // Error byte; low three bits are the sticky soft-error flags
  typedef struct packed {
    logic pll_unlock;
    logic trig_rate;
    logic trig_num_mismatch;
    logic trig_type_mismatch;
    logic data_corrupt;
    logic err_cs;
    logic err_unk;
    logic err_ovf;
  } hard_err_t;

  // One-cycle soft-error event pulses
  typedef struct packed {
    logic cs_mismatch;
    logic unknown_cmd;
    logic ddr3_overflow;
  } soft_err_evt_t;

  // Host-programmed thresholds, zero disables the flag
  typedef struct packed {
    logic [31:0] thres_cs;
    logic [31:0] thres_unk;
    logic [31:0] thres_ovf;
  } soft_thres_t;

  typedef struct packed {
    logic [31:0] cs_count;
    logic [31:0] unk_count;
    logic [31:0] ovf_count;
    logic        err_cs;
    logic        err_unk;
    logic        err_ovf;
  } soft_counts_t;

  // Front-panel trigger state; timestamp is the one captured at the last accept
  typedef struct packed {
    logic [23:0] trig_num;
    logic [43:0] timestamp;
    logic [31:0] raw_count;
    logic [31:0] acc_count;
  } trig_info_t;

  typedef struct packed {
    logic [3:0] tts_state;
    logic [5:0] ttc_chan_b_info;
    logic       ttc_ready;
  } ttc_status_t;

endpackage

`default_nettype wire

/* src/rider_bus_pkg.sv */
`default_nettype none

`include "rider_consts.svh"

package rider_bus_pkg;

  // Request held by the host from req rise until ack rise
  typedef struct packed {
    logic                   we;
    logic [`REG_ADDR_W-1:0] addr;
    logic [31:0]            wdata;
  } host_req_t;

  // Response held by the port while ack is high
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } host_rsp_t;

endpackage

`default_nettype wire

/* src/soft_error_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module soft_error_counters (
  input  logic                           clk,
  input  logic                           rst,
  input  rider_status_pkg::soft_err_evt_t evt,
  input  rider_status_pkg::soft_thres_t   thres,
  input  logic                           clear,
  output rider_status_pkg::soft_counts_t  counts
);

  // Index 2 is checksum, 1 is unknown command, 0 is DDR3 overflow
  logic [2:0]       evt_v;
  logic [2:0][31:0] thres_v;
  logic [2:0][31:0] cnt_q;
  logic [2:0][31:0] cnt_next;
  logic [2:0]       flag_q;

  assign evt_v   = {evt.cs_mismatch, evt.unknown_cmd, evt.ddr3_overflow};
  assign thres_v = {thres.thres_cs, thres.thres_unk, thres.thres_ovf};

  // Next count, held at all ones once saturated
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      if (evt_v[i] && (cnt_q[i] != '1)) begin
        cnt_next[i] = cnt_q[i] + 32'd1;
      end else begin
        cnt_next[i] = cnt_q[i];
      end
    end
  end

  // Clear from the host wins over an event in the same cycle
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      cnt_q  <= '0;
      flag_q <= '0;
    end else begin
      cnt_q <= cnt_next;
      for (int i = 0; i < 3; i++) begin
        // Sticky, a zero threshold never arms the flag
        if ((thres_v[i] != 32'd0) && (cnt_next[i] >= thres_v[i])) begin
          flag_q[i] <= 1'b1;
        end
      end
    end
  end

  // Back into named fields
  assign counts.cs_count  = cnt_q[2];
  assign counts.unk_count = cnt_q[1];
  assign counts.ovf_count = cnt_q[0];
  assign counts.err_cs    = flag_q[2];
  assign counts.err_unk   = flag_q[1];
  assign counts.err_ovf   = flag_q[0];

endmodule

`default_nettype wire

/* src/trigger_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_counters (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        ext_trigger,
  input  logic                        accept_triggers,
  output rider_status_pkg::trig_info_t trig
);

  logic [43:0] ts_q;
  logic [43:0] ts_cap_q;
  logic [23:0] trig_num_q;
  logic [31:0] raw_q;
  logic [31:0] acc_q;
  logic        accepted;

  // Trigger counted as accepted only while the gate is open
  assign accepted = ext_trigger && accept_triggers;

  // Free-running timestamp, zero in the first cycle out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      ts_q <= '0;
    end else begin
      ts_q <= ts_q + 44'd1;
    end
  end

  // Every front-panel pulse, accepted or not
  always_ff @(posedge clk) begin
    if (rst) begin
      raw_q <= '0;
    end else if (ext_trigger) begin
      raw_q <= raw_q + 32'd1;
    end
  end

  // Accepted count, trigger number and timestamp capture on the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      acc_q      <= '0;
      trig_num_q <= '0;
      ts_cap_q   <= '0;
    end else if (accepted) begin
      acc_q      <= acc_q + 32'd1;
      trig_num_q <= trig_num_q + 24'd1;
      ts_cap_q   <= ts_q;
    end
  end

  assign trig.trig_num  = trig_num_q;
  assign trig.timestamp = ts_cap_q;
  assign trig.raw_count = raw_q;
  assign trig.acc_count = acc_q;

endmodule

`default_nettype wire

/* src/status_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rider_consts.svh"

module status_regs (
  input  rider_status_pkg::board_flags_t flags,
  input  logic [4:0]                     ext_err,
  input  rider_status_pkg::soft_counts_t counts,
  input  rider_status_pkg::trig_info_t   trig,
  input  rider_status_pkg::ttc_status_t  ttc,
  input  logic [31:0]                    fsm_state,
  input  rider_status_pkg::soft_thres_t  thres,
  input  logic [`REG_ADDR_W-1:0]         rd_addr,
  output logic [31:0]                    rd_data
);

  rider_status_pkg::hard_err_t herr;
  logic [31:0] status_word;
  logic [31:0] error_word;

  // Outside errors on top, sticky soft flags below
  always_comb begin
    herr.pll_unlock         = ext_err[4];
    herr.trig_rate          = ext_err[3];
    herr.trig_num_mismatch  = ext_err[2];
    herr.trig_type_mismatch = ext_err[1];
    herr.data_corrupt       = ext_err[0];
    herr.err_cs             = counts.err_cs;
    herr.err_unk            = counts.err_unk;
    herr.err_ovf            = counts.err_ovf;
  end

  // Flags in bits 31:29, revision in the low three bytes
  assign status_word = {flags, 5'd0, `MAJOR_REV, `MINOR_REV, `PATCH_REV};
  assign error_word  = {24'd0, herr};

  // Read mux over the full 16-word map
  always_comb begin
    case (rd_addr)
      `ADDR_STATUS:    rd_data = status_word;
      `ADDR_ERRORS:    rd_data = error_word;
      `ADDR_CS_COUNT:  rd_data = counts.cs_count;
      `ADDR_UNK_COUNT: rd_data = counts.unk_count;
      `ADDR_OVF_COUNT: rd_data = counts.ovf_count;
      // Trigger number is 24 bits wide
      `ADDR_TRIG_NUM:  rd_data = {8'd0, trig.trig_num};
      `ADDR_TS_LSB:    rd_data = trig.timestamp[31:0];
      `ADDR_TS_MSB:    rd_data = {20'd0, trig.timestamp[43:32]};
      `ADDR_RAW_TRIG:  rd_data = trig.raw_count;
      `ADDR_ACC_TRIG:  rd_data = trig.acc_count;
      // TTS state, channel B info, ready in the low 11 bits
      `ADDR_TTC:       rd_data = {21'd0, ttc};
      `ADDR_FSM:       rd_data = fsm_state;
      `ADDR_THRES_CS:  rd_data = thres.thres_cs;
      `ADDR_THRES_UNK: rd_data = thres.thres_unk;
      `ADDR_THRES_OVF: rd_data = thres.thres_ovf;
      // Clear strobe has no storage behind it
      `ADDR_CLEAR:     rd_data = 32'd0;
      default:         rd_data = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

/* src/host_reg_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rider_consts.svh"

module host_reg_port (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req,
  input  rider_bus_pkg::host_req_t      hreq,
  output logic                          ack,
  output rider_bus_pkg::host_rsp_t      hrsp,
  output logic [`REG_ADDR_W-1:0]        rd_addr,
  input  logic [31:0]                   rd_data,
  output rider_status_pkg::soft_thres_t thres,
  output logic                          clear
);

  typedef enum logic {
    S_IDLE,
    S_ACK
  } state_t;

  state_t state_q;
  logic   req_q;
  logic   accept;
  logic   wr_en;
  logic   ro_addr;

  // Sample req one edge ahead of the FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req;
    end
  end

  // New transfer only while ack is low
  assign accept  = (state_q == S_IDLE) && req_q;
  assign wr_en   = accept && hreq.we;
  // Everything up to the FSM word is read-only
  assign ro_addr = (hreq.addr <= `ADDR_FSM);
  // Single-cycle strobe, lands on the ack-rise edge
  assign clear   = wr_en && (hreq.addr == `ADDR_CLEAR);
  assign rd_addr = hreq.addr;
  assign ack     = (state_q == S_ACK);

  // Four-phase handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: if (req_q) state_q <= S_ACK;
        S_ACK:  if (!req_q) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Threshold registers, written on the ack-rise edge
  always_ff @(posedge clk) begin
    if (rst) begin
      thres <= '0;
    end else if (wr_en) begin
      case (hreq.addr)
        `ADDR_THRES_CS:  thres.thres_cs  <= hreq.wdata;
        `ADDR_THRES_UNK: thres.thres_unk <= hreq.wdata;
        `ADDR_THRES_OVF: thres.thres_ovf <= hreq.wdata;
        default: ;
      endcase
    end
  end

  // Response captured once and held until ack falls
  always_ff @(posedge clk) begin
    if (accept) begin
      hrsp.rdata <= rd_data;
      hrsp.err   <= hreq.we && ro_addr;
    end
  end

endmodule

`default_nettype wire

/* src/rider_status_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rider_consts.svh"

module rider_status_top (
  input  logic                           clk,
  input  logic                           rst,
  // Host register port
  input  logic                           req,
  input  rider_bus_pkg::host_req_t       hreq,
  output logic                           ack,
  output rider_bus_pkg::host_rsp_t       hrsp,
  // Board status and hard errors
  input  rider_status_pkg::board_flags_t flags,
  input  logic [4:0]                     ext_err,
  // Soft-error pulses
  input  rider_status_pkg::soft_err_evt_t evt,
  // Front panel trigger
  input  logic                           ext_trigger,
  input  logic                           accept_triggers,
  // TTC/TTS and FSM state
  input  rider_status_pkg::ttc_status_t  ttc,
  input  logic [31:0]                    fsm_state
);

  rider_status_pkg::soft_thres_t  thres;
  rider_status_pkg::soft_counts_t counts;
  rider_status_pkg::trig_info_t   trig;
  logic [`REG_ADDR_W-1:0]         rd_addr;
  logic [31:0]                    rd_data;
  logic                           clear;

  soft_error_counters u_soft_error_counters (
    .clk    (clk),
    .rst    (rst),
    .evt    (evt),
    .thres  (thres),
    .clear  (clear),
    .counts (counts)
  );

  trigger_counters u_trigger_counters (
    .clk             (clk),
    .rst             (rst),
    .ext_trigger     (ext_trigger),
    .accept_triggers (accept_triggers),
    .trig            (trig)
  );

  // Read word selected straight from the request address
  status_regs u_status_regs (
    .flags     (flags),
    .ext_err   (ext_err),
    .counts    (counts),
    .trig      (trig),
    .ttc       (ttc),
    .fsm_state (fsm_state),
    .thres     (thres),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  host_reg_port u_host_reg_port (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .hreq    (hreq),
    .ack     (ack),
    .hrsp    (hrsp),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .thres   (thres),
    .clear   (clear)
  );

endmodule

`default_nettype wire

/* testbench/status_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rider_consts.svh"

module status_checker (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            req,
  input  rider_bus_pkg::host_req_t        hreq,
  input  logic                            ack,
  input  rider_bus_pkg::host_rsp_t        hrsp,
  input  rider_status_pkg::board_flags_t  flags,
  input  logic [4:0]                      ext_err,
  input  rider_status_pkg::soft_err_evt_t evt,
  input  logic                            ext_trigger,
  input  logic                            accept_triggers,
  input  rider_status_pkg::ttc_status_t   ttc,
  input  logic [31:0]                     fsm_state,
  output int                              errors,
  output int                              checks
);

  // Model index 0 is checksum, 1 unknown command, 2 DDR3 overflow
  logic        m_req_q;
  logic        m_ack;
  logic [31:0] m_cnt [3];
  logic [2:0]  m_flag;
  logic [31:0] m_thres [3];
  logic [43:0] m_ts;
  logic [43:0] m_ts_cap;
  logic [23:0] m_trig_num;
  logic [31:0] m_raw;
  logic [31:0] m_acc;
  // Expected response of the transfer in flight
  logic [3:0]  exp_addr;
  logic [31:0] exp_rdata;
  logic        exp_err;
  bit          ack_prev;
  rider_bus_pkg::host_rsp_t rsp_at_rise;

  // Word the host should see at an address, from the model state
  function automatic logic [31:0] model_word(input logic [3:0] addr);
    logic [31:0] w;
    case (addr)
      `ADDR_STATUS:    w = {flags, 5'd0, `MAJOR_REV, `MINOR_REV, `PATCH_REV};
      `ADDR_ERRORS:    w = {24'd0, ext_err, m_flag[0], m_flag[1], m_flag[2]};
      `ADDR_CS_COUNT:  w = m_cnt[0];
      `ADDR_UNK_COUNT: w = m_cnt[1];
      `ADDR_OVF_COUNT: w = m_cnt[2];
      `ADDR_TRIG_NUM:  w = {8'd0, m_trig_num};
      `ADDR_TS_LSB:    w = m_ts_cap[31:0];
      `ADDR_TS_MSB:    w = {20'd0, m_ts_cap[43:32]};
      `ADDR_RAW_TRIG:  w = m_raw;
      `ADDR_ACC_TRIG:  w = m_acc;
      `ADDR_TTC:       w = {21'd0, ttc.tts_state, ttc.ttc_chan_b_info, ttc.ttc_ready};
      `ADDR_FSM:       w = fsm_state;
      `ADDR_THRES_CS:  w = m_thres[0];
      `ADDR_THRES_UNK: w = m_thres[1];
      `ADDR_THRES_OVF: w = m_thres[2];
      default:         w = 32'd0;
    endcase
    return w;
  endfunction

  // Model step, inputs seen here are the values before the edge
  always @(posedge clk) begin : model_step
    logic       accept;
    logic       clr;
    logic [2:0] ev;
    if (rst) begin
      m_req_q    = 1'b0;
      m_ack      = 1'b0;
      m_flag     = '0;
      m_ts       = '0;
      m_ts_cap   = '0;
      m_trig_num = '0;
      m_raw      = '0;
      m_acc      = '0;
      for (int i = 0; i < 3; i++) begin
        m_cnt[i]   = '0;
        m_thres[i] = '0;
      end
    end else begin
      accept = !m_ack && m_req_q;
      // Read value is taken before anything moves at this edge
      if (accept) begin
        exp_addr  = hreq.addr;
        exp_rdata = model_word(hreq.addr);
        exp_err   = hreq.we && (hreq.addr <= `ADDR_FSM);
      end
      clr = accept && hreq.we && (hreq.addr == `ADDR_CLEAR);
      ev  = {evt.ddr3_overflow, evt.unknown_cmd, evt.cs_mismatch};
      // Counters compare against the thresholds held before this edge
      for (int i = 0; i < 3; i++) begin
        if (clr) begin
          m_cnt[i]  = '0;
          m_flag[i] = 1'b0;
        end else begin
          if (ev[i] && (m_cnt[i] != 32'hffff_ffff)) begin
            m_cnt[i] = m_cnt[i] + 32'd1;
          end
          if ((m_thres[i] != 32'd0) && (m_cnt[i] >= m_thres[i])) begin
            m_flag[i] = 1'b1;
          end
        end
      end
      if (accept && hreq.we) begin
        case (hreq.addr)
          `ADDR_THRES_CS:  m_thres[0] = hreq.wdata;
          `ADDR_THRES_UNK: m_thres[1] = hreq.wdata;
          `ADDR_THRES_OVF: m_thres[2] = hreq.wdata;
          default: ;
        endcase
      end
      // Triggers, capture takes the timestamp of the current cycle
      if (ext_trigger) begin
        m_raw = m_raw + 32'd1;
      end
      if (ext_trigger && accept_triggers) begin
        m_acc      = m_acc + 32'd1;
        m_trig_num = m_trig_num + 24'd1;
        m_ts_cap   = m_ts;
      end
      m_ts = m_ts + 44'd1;
      // Four-phase handshake, one edge of req sampling then one of ack
      if (accept) begin
        m_ack = 1'b1;
      end else if (m_ack && !m_req_q) begin
        m_ack = 1'b0;
      end
      m_req_q = req;
    end
  end

  // Compare in the middle of the cycle where outputs are settled
  always @(negedge clk) begin
    if (!rst) begin
      if (ack !== m_ack) begin
        errors++;
        if (m_ack) begin
          $display("Handshake error at time %0t: ack is low one edge after req was sampled high",
                   $time);
        end else begin
          $display("Handshake error at time %0t: ack is high with no request to acknowledge",
                   $time);
        end
      end else if (ack && !ack_prev) begin
        checks++;
        rsp_at_rise = hrsp;
        if ((hrsp.rdata !== exp_rdata) || (hrsp.err !== exp_err)) begin
          errors++;
          $display("Mismatch at time %0t: address %0d gave rdata %h err %b, expected %h err %b",
                   $time, exp_addr, hrsp.rdata, hrsp.err, exp_rdata, exp_err);
        end
      end else if (ack && (hrsp !== rsp_at_rise)) begin
        errors++;
        $display("Response changed at time %0t while ack was still high", $time);
      end
      ack_prev = ack;
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_rider_status.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rider_consts.svh"

module tb_rider_status;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam logic [31:0] SEED = 32'h57ef_7339;
  // Cycle budget per test, worst case of idle gaps and req hold
  localparam int T1_CYC = 300;
  localparam int T2_CYC = 300;
  localparam int T3_CYC = 800;
  localparam int T4_CYC = 400;
  localparam int T5_CYC = 900;
  localparam int T6_CYC = 700;
  localparam int WATCHDOG_NS = (RESET_CYCLES + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC
                                + T6_CYC) * CLK_PERIOD + 4000;

  logic                            clk;
  logic                            rst;
  logic                            req;
  rider_bus_pkg::host_req_t        hreq;
  logic                            ack;
  rider_bus_pkg::host_rsp_t        hrsp;
  rider_status_pkg::board_flags_t  flags;
  logic [4:0]                      ext_err;
  rider_status_pkg::soft_err_evt_t evt;
  logic                            ext_trigger;
  logic                            accept_triggers;
  rider_status_pkg::ttc_status_t   ttc;
  logic [31:0]                     fsm_state;

  // Background stimulus control, changed only at falling edges
  logic        evt_en;
  logic        evt_force;
  logic        trig_en;
  logic [31:0] main_state;
  logic [31:0] bg_state;
  logic [31:0] rdata;
  logic        err;
  logic [31:0] wval;
  logic [31:0] r;
  int          tb_errors;
  int          chk_errors;
  int          chk_checks;
  int          last_errors;

  rider_status_top u_rider_status_top (
    .clk (clk), .rst (rst), .req (req), .hreq (hreq), .ack (ack), .hrsp (hrsp),
    .flags (flags), .ext_err (ext_err), .evt (evt), .ext_trigger (ext_trigger),
    .accept_triggers (accept_triggers), .ttc (ttc), .fsm_state (fsm_state)
  );

  status_checker u_status_checker (
    .clk (clk), .rst (rst), .req (req), .hreq (hreq), .ack (ack), .hrsp (hrsp),
    .flags (flags), .ext_err (ext_err), .evt (evt), .ext_trigger (ext_trigger),
    .accept_triggers (accept_triggers), .ttc (ttc), .fsm_state (fsm_state),
    .errors (chk_errors), .checks (chk_checks)
  );

  // Galois LFSR, x^32+x^22+x^2+x+1, one step per bit taken
  function automatic logic [31:0] rand_bits(inout logic [31:0] st, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = (st >> 1) ^ (st[0] ? 32'h8020_0003 : 32'h0);
      v  = {v[30:0], st[0]};
    end
    return v;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Full four-phase transfer, req held a random 0 to 7 extra cycles
  task automatic host_xfer(input logic wr, input logic [`REG_ADDR_W-1:0] addr,
                           input logic [31:0] wdata);
    int n;
    int hold;
    hold = rand_bits(main_state, 3);
    @(posedge clk);
    hreq.we    <= wr;
    hreq.addr  <= addr;
    hreq.wdata <= wdata;
    req        <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!ack && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!ack) begin
      tb_errors++;
      $display("No ack came for the request to address %0d", addr);
    end
    rdata = hrsp.rdata;
    err   = hrsp.err;
    repeat (hold) @(posedge clk);
    @(posedge clk);
    req <= 1'b0;
    n = 0;
    @(negedge clk);
    while (ack && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (ack) begin
      tb_errors++;
      $display("ack stayed high after req was dropped at address %0d", addr);
    end
  endtask

  task automatic report_test(input string name);
    int total;
    total = tb_errors + chk_errors;
    $display("test %s: %0d errors", name, total - last_errors);
    last_errors = total;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Soft-error pulses and front-panel triggers
  initial begin
    bg_state = SEED;
    evt             <= '0;
    ext_trigger     <= 1'b0;
    accept_triggers <= 1'b0;
    forever begin
      @(posedge clk);
      r = rand_bits(bg_state, 8);
      if (evt_force) begin
        evt <= 3'b111;
      end else if (evt_en) begin
        evt <= r[2:0] & r[5:3];
      end else begin
        evt <= '0;
      end
      ext_trigger     <= trig_en && r[6];
      accept_triggers <= trig_en && r[7];
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    main_state = SEED;
    evt_en = 1'b0;
    evt_force = 1'b0;
    trig_en = 1'b0;
    tb_errors = 0;
    last_errors = 0;
    rst <= 1'b1;
    req <= 1'b0;
    hreq <= '0;
    flags <= '0;
    ext_err <= '0;
    ttc <= '0;
    fsm_state <= '0;
    @(posedge clk);
    wval = rand_bits(main_state, 19);
    flags     <= wval[2:0];
    ext_err   <= wval[7:3];
    ttc       <= wval[18:8];
    fsm_state <= rand_bits(main_state, 32);
    repeat (RESET_CYCLES - 1) @(posedge clk);
    rst <= 1'b0;

    // Counters, trigger data and thresholds start at zero
    for (int a = 0; a < 16; a++) begin
      host_xfer(1'b0, 4'(a), 32'd0);
      if (((a >= 2 && a <= 9) || a >= 12) && rdata !== 32'd0) begin
        tb_errors++;
        $display("Mismatch at time %0t: address %0d read %h after reset", $time, a, rdata);
      end
    end
    report_test("reset values");

    for (int a = 12; a < 15; a++) begin
      wval = rand_bits(main_state, 32);
      host_xfer(1'b1, 4'(a), wval);
      host_xfer(1'b0, 4'(a), 32'd0);
      if (rdata !== wval) begin
        tb_errors++;
        $display("Mismatch at time %0t: threshold %0d read %h, wrote %h", $time, a, rdata, wval);
      end
    end
    for (int k = 0; k < 4; k++) begin
      wval = rand_bits(main_state, 4) % 12;
      host_xfer(1'b1, wval[3:0], rand_bits(main_state, 32));
      if (err !== 1'b1) begin
        tb_errors++;
        $display("Mismatch at time %0t: write to address %0d gave err 0", $time, wval[3:0]);
      end
      host_xfer(1'b0, wval[3:0], 32'd0);
    end
    report_test("thresholds and errors");

    // Small thresholds on two counters, overflow flag disabled
    host_xfer(1'b1, `ADDR_THRES_CS, 32'd1 + rand_bits(main_state, 3));
    host_xfer(1'b1, `ADDR_THRES_UNK, 32'd1 + rand_bits(main_state, 3));
    host_xfer(1'b1, `ADDR_THRES_OVF, 32'd0);
    evt_en = 1'b1;
    for (int k = 0; k < 30; k++) begin
      idle(rand_bits(main_state, 2));
      host_xfer(1'b0, 4'(32'd1 + rand_bits(main_state, 2)), 32'd0);
    end
    evt_en = 1'b0;
    host_xfer(1'b1, `ADDR_THRES_CS, 32'hffff_ffff);
    host_xfer(1'b0, `ADDR_ERRORS, 32'd0);
    if (rdata[2] !== 1'b1 || rdata[0] !== 1'b0) begin
      tb_errors++;
      $display("Mismatch at time %0t: soft flags read %b", $time, rdata[2:0]);
    end
    report_test("soft-error counting");

    for (int a = 12; a < 15; a++) begin
      host_xfer(1'b1, 4'(a), 32'd2);
    end
    evt_en = 1'b1;
    idle(20);
    evt_en = 1'b0;
    host_xfer(1'b0, `ADDR_ERRORS, 32'd0);
    for (int a = 12; a < 15; a++) begin
      host_xfer(1'b1, 4'(a), 32'd1000);
    end
    // Events forced on every cycle until the clear is acknowledged
    evt_force = 1'b1;
    fork
      host_xfer(1'b1, `ADDR_CLEAR, 32'hdead_beef);
      begin
        @(negedge clk);
        while (!ack) @(negedge clk);
        evt_force = 1'b0;
      end
    join
    if (err !== 1'b0) begin
      tb_errors++;
      $display("Mismatch at time %0t: clear write gave err 1", $time);
    end
    for (int a = 1; a < 5; a++) begin
      host_xfer(1'b0, 4'(a), 32'd0);
      if (a == 1 && rdata[2:0] !== 3'b000) begin
        tb_errors++;
        $display("Mismatch at time %0t: flags %b after clear", $time, rdata[2:0]);
      end
    end
    report_test("clear");

    trig_en = 1'b1;
    for (int k = 0; k < 40; k++) begin
      idle(rand_bits(main_state, 2));
      host_xfer(1'b0, 4'(32'd5 + rand_bits(main_state, 2)), 32'd0);
    end
    trig_en = 1'b0;
    for (int a = 5; a < 10; a++) begin
      host_xfer(1'b0, 4'(a), 32'd0);
    end
    report_test("triggers");

    // Any address, reads and writes, with all activity running
    evt_en = 1'b1;
    trig_en = 1'b1;
    for (int k = 0; k < 40; k++) begin
      wval = rand_bits(main_state, 5);
      host_xfer(wval[0], wval[4:1], rand_bits(main_state, 32));
    end
    evt_en = 1'b0;
    trig_en = 1'b0;
    idle(4);
    report_test("handshake");

    $display("%0d responses compared, %0d errors", chk_checks, tb_errors + chk_errors);
    if (tb_errors + chk_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/rider_status_pkg.sv
src/rider_bus_pkg.sv
src/soft_error_counters.sv
src/trigger_counters.sv
src/status_regs.sv
src/host_reg_port.sv
src/rider_status_top.sv
testbench/status_checker.sv
testbench/tb_rider_status.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the status subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_rider_status -Mdir obj_dir -o sim_rider
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_rider > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
  exit 1
fi
exit 0
